//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rob
FILELIST ?= all.f
SRCS ?= $(shell grep -v '^+' $(FILELIST))
HDRS ?= rob_settings.svh
BUILD ?= obj_dir
LOG ?= sim.log

BIN := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
+incdir+.
rob_pkg.sv
rob_decode.sv
rob_queue.sv
rob_commit.sv
rob_top.sv
rob_checker.sv
tb_rob.sv

//--- rob_checker.sv
`include "rob_settings.svh"

module rob_checker (
  input logic clk,
  input logic rst,
  input rob_pkg::alloc_t alloc,
  input logic alloc_valid,
  input logic alloc_ready,
  input logic [`ROB_TAG_W-1:0] alloc_tag,
  input rob_pkg::cdb_t cdb,
  input rob_pkg::retire_t retire,
  input rob_pkg::redirect_t redirect,
  input logic test_end,
  input logic [127:0] test_name,
  input logic all_done,
  output logic drained,
  output int errors
);

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic is_branch;
    logic done;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0] value;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] next_pc;
    logic pred_taken;
    logic taken;
  } model_t;

  model_t q[$];
  model_t head;
  rob_pkg::retire_t exp_ret;
  rob_pkg::redirect_t exp_red;
  logic [`ROB_TAG_W-1:0] tail;
  logic flushed;
  logic found;
  int test_errors = 0;
  int tests = 0;
  int failed_tests = 0;

  initial errors = 0;

  // expected entry straight from the instruction encoding
  function automatic model_t predict_entry(rob_pkg::alloc_t a, logic [`ROB_TAG_W-1:0] tag);
    logic [31:0] w;
    model_t m;
    w = a.insn;
    m = '0;
    m.tag = tag;
    m.dest = w[11:7];
    m.pred_taken = a.pred_taken;
    m.next_pc = a.pc + (a.is_half ? `XLEN'(2) : `XLEN'(4));
    case (w[6:0])
      `OP_LUI: begin
        m.done = 1'b1;
        m.value = {w[31:12], 12'b0};
      end
      `OP_AUIPC: begin
        m.done = 1'b1;
        m.value = {w[31:12], 12'b0} + a.pc;
      end
      `OP_JAL: begin
        m.done = 1'b1;
        m.value = m.next_pc;
      end
      `OP_BRANCH: begin
        m.is_branch = 1'b1;
        m.dest = '0;
        m.target = a.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      default: begin
      end
    endcase
    return m;
  endfunction

  task automatic compare(string name, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] got);
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      test_errors++;
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      q.delete();
      exp_ret = '0;
      exp_red = '0;
      tail = '0;
    end else begin
      // outputs registered at the previous edge
      compare("retire.we", `XLEN'(exp_ret.we), `XLEN'(retire.we));
      if (exp_ret.we) begin
        compare("retire.addr", `XLEN'(exp_ret.addr), `XLEN'(retire.addr));
        compare("retire.data", exp_ret.data, retire.data);
        compare("retire.tag", `XLEN'(exp_ret.tag), `XLEN'(retire.tag));
      end
      compare("redirect.valid", `XLEN'(exp_red.valid), `XLEN'(redirect.valid));
      if (exp_red.valid) begin
        compare("redirect.pc", exp_red.pc, redirect.pc);
      end
      compare("alloc_ready", `XLEN'(q.size() < `ROB_DEPTH), `XLEN'(alloc_ready));

      exp_ret = '0;
      exp_red = '0;
      flushed = 1'b0;
      if (q.size() > 0 && q[0].done) begin
        head = q.pop_front();
        if (!head.is_branch) begin
          exp_ret = '{we: 1'b1, addr: head.dest, data: head.value, tag: head.tag};
        end else if (head.taken != head.pred_taken) begin
          exp_red.valid = 1'b1;
          exp_red.pc = head.taken ? head.target : head.next_pc;
          // wrong path work is dropped
          q.delete();
          tail = '0;
          flushed = 1'b1;
        end
      end

      if (cdb.valid && !flushed) begin
        found = 1'b0;
        foreach (q[i]) begin
          if (q[i].tag == cdb.tag) begin
            if (q[i].done) begin
              $display("completion at %0t for tag %0d, which was already done", $time, cdb.tag);
              test_errors++;
              errors++;
            end
            q[i].done = 1'b1;
            q[i].value = cdb.value;
            q[i].taken = cdb.taken;
            found = 1'b1;
          end
        end
        if (!found) begin
          $display("completion at %0t for tag %0d, which is not in flight", $time, cdb.tag);
          test_errors++;
          errors++;
        end
      end

      if (alloc_valid && alloc_ready && !flushed) begin
        compare("alloc_tag", `XLEN'(tail), `XLEN'(alloc_tag));
        q.push_back(predict_entry(alloc, tail));
        tail++;
      end
    end
    drained = (q.size() == 0) && !exp_ret.we && !exp_red.valid;

    if (test_end) begin
      tests++;
      if (test_errors == 0) begin
        $display("test %s passed", test_name);
      end else begin
        $display("test %s failed with %0d errors", test_name, test_errors);
        failed_tests++;
      end
      test_errors = 0;
    end
    if (all_done) begin
      $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    end
  end

endmodule

//--- rob_commit.sv
`include "rob_settings.svh"

module rob_commit (
  input logic clk,
  input logic rst,
  input rob_pkg::rob_entry_t head_entry,
  input logic head_ready,
  input logic [`ROB_TAG_W-1:0] head_tag,
  output logic flush,
  output rob_pkg::retire_t retire,
  output rob_pkg::redirect_t redirect
);

  logic is_branch;
  logic mispredict;
  logic [`XLEN-1:0] fall_through;

  assign is_branch = head_entry.kind == rob_pkg::KIND_BRANCH;
  assign mispredict = head_ready && is_branch && (head_entry.taken != head_entry.pred_taken);
  assign fall_through = head_entry.pc + (head_entry.is_half ? `XLEN'(2) : `XLEN'(4));

  // younger entries are wrong path
  assign flush = mispredict;

  always_ff @(posedge clk) begin
    retire.addr <= head_entry.dest;
    retire.data <= head_entry.value;
    retire.tag <= head_tag;
    redirect.pc <= head_entry.taken ? head_entry.target : fall_through;
    if (rst) begin
      retire.we <= 1'b0;
      redirect.valid <= 1'b0;
    end else begin
      retire.we <= head_ready && !is_branch;
      redirect.valid <= mispredict;
    end
  end

  // queue is empty after a redirect, so no write follows it
  assert property (@(posedge clk) disable iff (rst)
    redirect.valid |=> !retire.we);

endmodule

//--- rob_decode.sv
`include "rob_settings.svh"

module rob_decode (
  input rob_pkg::alloc_t alloc,
  output rob_pkg::rob_entry_t entry
);

  logic [`XLEN-1:0] upper_imm;
  logic [`XLEN-1:0] b_imm;
  logic [`XLEN-1:0] link;

  // same word, two views
  assign upper_imm = {alloc.insn.uj.imm_hi, 12'b0};
  assign b_imm = {{(`XLEN-12){alloc.insn.b.imm12}}, alloc.insn.b.imm11,
                  alloc.insn.b.imm10_5, alloc.insn.b.imm4_1, 1'b0};

  // compressed instructions are two bytes long
  assign link = alloc.pc + (alloc.is_half ? `XLEN'(2) : `XLEN'(4));

  always_comb begin
    entry = '0;
    entry.busy = 1'b1;
    entry.pc = alloc.pc;
    entry.is_half = alloc.is_half;
    entry.pred_taken = alloc.pred_taken;
    entry.dest = alloc.insn.uj.rd;
    entry.kind = rob_pkg::KIND_ALU;

    case (alloc.insn.uj.opcode)
      `OP_LUI: begin
        entry.kind = rob_pkg::KIND_LUI;
        entry.value = upper_imm;
        entry.done = 1'b1;
      end
      `OP_AUIPC: begin
        entry.kind = rob_pkg::KIND_AUIPC;
        entry.value = upper_imm + alloc.pc;
        entry.done = 1'b1;
      end
      `OP_JAL: begin
        entry.kind = rob_pkg::KIND_JAL;
        entry.value = link;
        entry.done = 1'b1;
      end
      `OP_BRANCH: begin
        // rd bits hold immediate here, no destination
        entry.kind = rob_pkg::KIND_BRANCH;
        entry.dest = '0;
        entry.target = alloc.pc + b_imm;
      end
      `OP_OP_IMM, `OP_OP: begin
        entry.kind = rob_pkg::KIND_ALU;
      end
      default: begin
        // anything else waits for the cdb like an alu op
        entry.kind = rob_pkg::KIND_ALU;
      end
    endcase
  end

endmodule

//--- rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

  typedef enum logic [2:0] {
    KIND_ALU,
    KIND_BRANCH,
    KIND_LUI,
    KIND_AUIPC,
    KIND_JAL
  } rob_kind_t;

  // U and J formats share this layout
  typedef struct packed {
    logic [19:0] imm_hi;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0] opcode;
  } insn_uj_t;

  // branch immediate is scattered over the word
  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef union packed {
    insn_uj_t uj;
    insn_b_t b;
  } insn_u;

  typedef struct packed {
    insn_u insn;
    logic [`XLEN-1:0] pc;
    logic is_half;
    logic pred_taken;
  } alloc_t;

  typedef struct packed {
    logic busy;
    logic done;
    rob_kind_t kind;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`XLEN-1:0] value;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] target;
    logic is_half;
    logic pred_taken;
    logic taken;
  } rob_entry_t;

  typedef struct packed {
    logic valid;
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0] value;
    logic taken;
  } cdb_t;

  typedef struct packed {
    logic we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0] data;
    logic [`ROB_TAG_W-1:0] tag;
  } retire_t;

  typedef struct packed {
    logic valid;
    logic [`XLEN-1:0] pc;
  } redirect_t;

endpackage

//--- rob_queue.sv
`include "rob_settings.svh"

module rob_queue (
  input logic clk,
  input logic rst,
  input rob_pkg::rob_entry_t entry,
  input logic alloc_valid,
  output logic alloc_ready,
  output logic [`ROB_TAG_W-1:0] alloc_tag,
  input rob_pkg::cdb_t cdb,
  input logic flush,
  output rob_pkg::rob_entry_t head_entry,
  output logic head_ready,
  output logic [`ROB_TAG_W-1:0] head_tag
);

  localparam logic [`ROB_TAG_W:0] FULL = (`ROB_TAG_W + 1)'(`ROB_DEPTH);

  rob_pkg::rob_entry_t mem [`ROB_DEPTH];

  logic [`ROB_DEPTH-1:0] busy_q;
  logic [`ROB_DEPTH-1:0] done_q;
  logic [`ROB_TAG_W-1:0] head;
  logic [`ROB_TAG_W-1:0] tail;
  logic [`ROB_TAG_W:0] count;
  logic push;
  logic pop;

  assign alloc_ready = count < FULL;
  assign alloc_tag = tail;
  assign push = alloc_valid && alloc_ready;

  assign head_tag = head;
  assign head_ready = busy_q[head] && done_q[head];
  assign pop = head_ready;

  // control bits live beside the payload
  always_comb begin
    head_entry = mem[head];
    head_entry.busy = busy_q[head];
    head_entry.done = done_q[head];
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      busy_q <= '0;
      done_q <= '0;
    end else begin
      if (push) begin
        busy_q[tail] <= 1'b1;
        done_q[tail] <= entry.done;
        tail <= tail + 1'b1;
      end
      if (cdb.valid) begin
        done_q[cdb.tag] <= 1'b1;
      end
      if (pop) begin
        busy_q[head] <= 1'b0;
        done_q[head] <= 1'b0;
        head <= head + 1'b1;
      end
      count <= count + {{`ROB_TAG_W{1'b0}}, push} - {{`ROB_TAG_W{1'b0}}, pop};
    end
  end

  // early results arrive with the entry payload
  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail] <= entry;
    end
    if (cdb.valid) begin
      mem[cdb.tag].value <= cdb.value;
      mem[cdb.tag].taken <= cdb.taken;
    end
  end

  // completions only target entries still waiting
  assert property (@(posedge clk) disable iff (rst)
    cdb.valid |-> busy_q[cdb.tag] && !done_q[cdb.tag]);

  // a new entry never lands on a live one
  assert property (@(posedge clk) disable iff (rst)
    push |-> !busy_q[tail]);

endmodule

//--- rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// queue geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// datapath widths
`define XLEN 32
`define REG_ADDR_W 5

// base opcodes handled by the buffer
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_JAL 7'b1101111
`define OP_OP_IMM 7'b0010011
`define OP_OP 7'b0110011
`define OP_BRANCH 7'b1100011

`endif

//--- rob_top.sv
`include "rob_settings.svh"

module rob_top (
  input logic clk,
  input logic rst,
  input rob_pkg::alloc_t alloc,
  input logic alloc_valid,
  output logic alloc_ready,
  output logic [`ROB_TAG_W-1:0] alloc_tag,
  input rob_pkg::cdb_t cdb,
  output rob_pkg::retire_t retire,
  output rob_pkg::redirect_t redirect
);

  rob_pkg::rob_entry_t entry;
  rob_pkg::rob_entry_t head_entry;
  logic head_ready;
  logic [`ROB_TAG_W-1:0] head_tag;
  logic flush;

  rob_decode u_decode (
    .alloc(alloc),
    .entry(entry)
  );

  rob_queue u_queue (
    .clk(clk),
    .rst(rst),
    .entry(entry),
    .alloc_valid(alloc_valid),
    .alloc_ready(alloc_ready),
    .alloc_tag(alloc_tag),
    .cdb(cdb),
    .flush(flush),
    .head_entry(head_entry),
    .head_ready(head_ready),
    .head_tag(head_tag)
  );

  rob_commit u_commit (
    .clk(clk),
    .rst(rst),
    .head_entry(head_entry),
    .head_ready(head_ready),
    .head_tag(head_tag),
    .flush(flush),
    .retire(retire),
    .redirect(redirect)
  );

endmodule

//--- tb_rob.sv
`include "rob_settings.svh"

module tb_rob;

  typedef enum {ACT_ALLOC, ACT_DONE, ACT_HOLD} act_e;

  typedef struct {
    rob_pkg::alloc_t a;
    act_e act;
    int arg;
    logic [`XLEN-1:0] value;
    logic taken;
    logic [127:0] name;
  } row_t;

  logic clk;
  logic rst;
  rob_pkg::alloc_t alloc;
  logic alloc_valid;
  logic alloc_ready;
  logic [`ROB_TAG_W-1:0] alloc_tag;
  rob_pkg::cdb_t cdb;
  rob_pkg::retire_t retire;
  rob_pkg::redirect_t redirect;
  logic test_end;
  logic [127:0] test_name;
  logic all_done;
  logic drained;
  int errors;
  row_t rows[$];
  int cycles = 0;
  int limit = 0;

  rob_top dut (
    .clk(clk),
    .rst(rst),
    .alloc(alloc),
    .alloc_valid(alloc_valid),
    .alloc_ready(alloc_ready),
    .alloc_tag(alloc_tag),
    .cdb(cdb),
    .retire(retire),
    .redirect(redirect)
  );

  rob_checker chk (
    .clk(clk),
    .rst(rst),
    .alloc(alloc),
    .alloc_valid(alloc_valid),
    .alloc_ready(alloc_ready),
    .alloc_tag(alloc_tag),
    .cdb(cdb),
    .retire(retire),
    .redirect(redirect),
    .test_end(test_end),
    .test_name(test_name),
    .all_done(all_done),
    .drained(drained),
    .errors(errors)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  // addi rd, x1, 1
  function automatic logic [31:0] alu(logic [4:0] rd);
    return u_type(`OP_OP_IMM, rd, 20'h00108);
  endfunction

  // beq x1, x2 with a byte offset
  function automatic logic [31:0] b_type(logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  task automatic add_alloc(logic [31:0] word, logic [31:0] pc, logic half, logic pred,
                           logic [127:0] name);
    row_t r;
    r = '{a: {word, pc, half, pred}, act: ACT_ALLOC, arg: 0, value: '0, taken: 1'b0,
          name: name};
    rows.push_back(r);
  endtask

  task automatic add_done(int tag, logic taken, logic [127:0] name);
    row_t r;
    r = '{a: '0, act: ACT_DONE, arg: tag, value: $urandom, taken: taken, name: name};
    rows.push_back(r);
  endtask

  task automatic add_hold(int n, logic [127:0] name);
    row_t r;
    r = '{a: '0, act: ACT_HOLD, arg: n, value: '0, taken: 1'b0, name: name};
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_alloc(u_type(`OP_LUI, 5'd1, 20'h12345), 32'h100, 1'b0, 1'b0, "early");
    add_alloc(u_type(`OP_AUIPC, 5'd2, 20'h00001), 32'h104, 1'b0, 1'b0, "early");
    add_alloc(u_type(`OP_JAL, 5'd3, 20'h00010), 32'h108, 1'b0, 1'b0, "early");
    // tags 3 to 5, youngest completes first
    for (int i = 0; i < 3; i++) begin
      add_alloc(alu(5'(10 + i)), 32'h110 + 4 * i, 1'b0, 1'b0, "cdb_order");
    end
    for (int i = 5; i >= 3; i--) begin
      add_done(i, 1'b0, "cdb_order");
    end
    // tags 6 to 15 then 0 to 5, the extra one waits for a free slot
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      add_alloc(alu(5'(i)), 32'h1000 + 4 * i, 1'b0, 1'b0, "full");
    end
    add_done(6, 1'b0, "full");
    add_alloc(alu(5'd20), 32'h1040, 1'b0, 1'b0, "full");
    for (int i = 7; i < 22; i++) begin
      add_done(i % 16, 1'b0, "full");
    end
    add_done(6, 1'b0, "full");
    add_alloc(b_type(13'h040), 32'h200, 1'b0, 1'b1, "branch_hit");
    add_alloc(alu(5'd5), 32'h204, 1'b0, 1'b0, "branch_hit");
    add_done(7, 1'b1, "branch_hit");
    add_done(8, 1'b0, "branch_hit");
    // backward branch at tag 9, younger work already finished
    add_alloc(b_type(13'h1fe0), 32'h300, 1'b0, 1'b0, "mispredict");
    add_alloc(alu(5'd6), 32'h304, 1'b0, 1'b0, "mispredict");
    add_alloc(u_type(`OP_LUI, 5'd7, 20'habcde), 32'h308, 1'b0, 1'b0, "mispredict");
    add_done(10, 1'b0, "mispredict");
    add_done(9, 1'b1, "mispredict");
    add_hold(2, "mispredict");
    add_alloc(b_type(13'h080), 32'h400, 1'b0, 1'b1, "mispredict_nt");
    add_done(0, 1'b0, "mispredict_nt");
    add_alloc(u_type(`OP_JAL, 5'd8, 20'h00000), 32'h500, 1'b1, 1'b0, "compressed");
    add_alloc(b_type(13'h010), 32'h502, 1'b1, 1'b1, "compressed");
    add_done(1, 1'b0, "compressed");
  endtask

  task automatic apply_row(row_t r);
    case (r.act)
      ACT_ALLOC: begin
        alloc = r.a;
        alloc_valid = 1'b1;
        while (!alloc_ready) @(negedge clk);
        @(negedge clk);
        alloc_valid = 1'b0;
      end
      ACT_DONE: begin
        cdb = '{valid: 1'b1, tag: (`ROB_TAG_W)'(r.arg), value: r.value, taken: r.taken};
        @(negedge clk);
        cdb.valid = 1'b0;
      end
      default: begin
        repeat (r.arg) @(negedge clk);
      end
    endcase
  endtask

  task automatic finish_test(logic [127:0] name);
    while (!drained) @(negedge clk);
    test_name = name;
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h7e2b3803));
    rst = 1'b1;
    alloc = '0;
    alloc_valid = 1'b0;
    cdb = '0;
    test_end = 1'b0;
    test_name = '0;
    all_done = 1'b0;
    build_table();
    limit = rows.size() * 20 + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (rows[i]) begin
      apply_row(rows[i]);
      if (i == rows.size() - 1 || rows[i + 1].name != rows[i].name) begin
        finish_test(rows[i].name);
      end
    end

    all_done = 1'b1;
    @(negedge clk);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
